// File: Bender.yml
package:
  name: exec_stage

sources:
  - rtl/rv32_isa_pkg.sv
  - rtl/exec_stage_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/reg_file.sv
  - rtl/int_execute.sv
  - rtl/load_store_unit.sv
  - rtl/writeback_select.sv
  - rtl/exec_stage_top.sv
  - target: test
    files:
      - bench/exec_stage_tb.sv

// File: bench/exec_stage_tb.sv
// ----------------------------------------
// execute stage testbench with clock, reset, memory model
// shadow registers, random stimulus, assertions
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb import rv32_isa_pkg::*, exec_stage_pkg::*;;

  localparam int RESET_CYCLES = 2;
  localparam int N_ITEMS      = 300;   // random items with two instructions per load or store
  localparam int N_TAIL       = 8;     // items run after halt
  // one cycle per instruction and at most two per item plus init and halt steps
  localparam int MAX_CYCLES   = RESET_CYCLES + 1 + 2 * 30 + 2 + 2 * (N_ITEMS + N_TAIL) + 16;

  localparam logic [6:0] OP_LUI    = 7'h37;
  localparam logic [6:0] OP_AUIPC  = 7'h17;
  localparam logic [6:0] OP_JAL    = 7'h6f;
  localparam logic [6:0] OP_JALR   = 7'h67;
  localparam logic [6:0] OP_BRANCH = 7'h63;
  localparam logic [6:0] OP_LOAD   = 7'h03;
  localparam logic [6:0] OP_STORE  = 7'h23;
  localparam logic [6:0] OP_IMM    = 7'h13;
  localparam logic [6:0] OP_REG    = 7'h33;
  localparam word_t      HALT_WORD = 32'h0000_007f;

  logic      CLK = 1'b0;
  logic      nRST;
  fetch_ex_t fetch_ex;
  logic      stall;
  word_t     dmem_rdata;
  mem_req_t  dmem;
  redirect_t redirect;
  wb_t       wb;
  logic      mal_load, mal_store, halt;

  word_t mem [256];      // word indexed data memory
  word_t shadow [32];    // expected register contents
  word_t pc_q;
  int    cycle_cnt = 0;

  exec_stage_top #(.little_endian_bus(1'b1)) dut0 (
    .CLK        (CLK),
    .nRST       (nRST),
    .fetch_ex   (fetch_ex),
    .stall      (stall),
    .dmem_rdata (dmem_rdata),
    .dmem       (dmem),
    .redirect   (redirect),
    .wb         (wb),
    .mal_load   (mal_load),
    .mal_store  (mal_store),
    .halt       (halt)
  );

  always #50 CLK = ~CLK;

  // bus answers in the same cycle
  assign dmem_rdata = mem[dmem.addr[9:2]];

  always @(posedge CLK) begin
    if (dmem.wen) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem.byte_en[k]) begin
          mem[dmem.addr[9:2]][8*k +: 8] <= dmem.wdata[8*k +: 8];
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run("run stopped at the cycle limit before the tests finished");
    end
  end

  task automatic mismatch(input string name, input word_t exp, input word_t act);
    $display("error %s: expected %h, actual %h", name, exp, act);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // protocol rules checked every edge
  assert property (@(posedge CLK) disable iff (!nRST) stall |-> !wb.wen)
    else abort_run("register write seen while stall is high");
  assert property (@(posedge CLK) disable iff (!nRST)
                   (mal_load || mal_store) |-> !(dmem.ren || dmem.wen))
    else abort_run("bus access issued for a misaligned address");
  assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else abort_run("halt dropped without a reset");

  // instruction encoders
  function automatic word_t r_word(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic word_t i_word(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_word(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_word(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t j_word(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // rv32i arithmetic by funct3 with alt from instruction bit 30
  function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
    word_t res;
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b110:  res = a | b;
      3'b111:  res = a & b;
      default: begin
        if (alt) res = $signed(a) >>> b[4:0];  // arithmetic shift
        else res = a >> b[4:0];
      end
    endcase
    return res;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic misaligned(input logic [2:0] f3, input word_t addr);
    case (f3[1:0])
      2'b01:   return addr[0];
      2'b10:   return addr[1:0] != 2'b00;
      default: return 1'b0;
    endcase
  endfunction

  // load value from the memory model in little-endian lanes
  function automatic word_t load_value(input logic [2:0] f3, input word_t addr);
    word_t       w;
    logic [7:0]  b8;
    logic [15:0] h16;
    w   = mem[addr[9:2]];
    b8  = 8'(w >> {addr[1:0], 3'b000});
    h16 = addr[1] ? w[31:16] : w[15:0];
    case (f3)
      3'b000:  return {{24{b8[7]}}, b8};
      3'b100:  return {24'b0, b8};
      3'b001:  return {{16{h16[15]}}, h16};
      3'b101:  return {16'b0, h16};
      default: return w;
    endcase
  endfunction

  function automatic logic [3:0] byte_lanes(input logic [2:0] f3, input word_t addr);
    case (f3[1:0])
      2'b00:   return 4'b0001 << addr[1:0];
      2'b01:   return addr[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic word_t store_data(input logic [2:0] f3, input word_t d);
    case (f3[1:0])
      2'b00:   return {4{d[7:0]}};
      2'b01:   return {2{d[15:0]}};
      default: return d;
    endcase
  endfunction

  // x1 is kept as the load/store base register
  function automatic reg_addr_t pick_rd();
    int r;
    r = $urandom_range(0, 31);
    return (r == 1) ? 5'd0 : 5'(r);
  endfunction

  // drives one instruction and checks it before the edge then updates shadow
  task automatic run_instr(input word_t w, input logic stall_v);
    logic [6:0] op;
    logic [2:0] f3;
    reg_addr_t  rd, rs1, rs2;
    word_t      a, b, pc4, addr, exp_data, exp_target, opb;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    logic       pred, writes, taken, mis, exp_wen;
    string      name;
    op    = w[6:0];
    rd    = w[11:7];
    f3    = w[14:12];
    rs1   = w[19:15];
    rs2   = w[24:20];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    pred  = 1'($urandom_range(0, 1));
    @(negedge CLK);
    fetch_ex.instr      = w;
    fetch_ex.pc         = pc_q;
    fetch_ex.pc4        = pc_q + 32'd4;
    fetch_ex.prediction = pred;
    stall               = stall_v;
    a          = shadow[rs1];
    b          = shadow[rs2];
    pc4        = pc_q + 32'd4;
    writes     = 1'b0;
    taken      = 1'b0;
    mis        = 1'b0;
    addr       = '0;
    exp_data   = '0;
    exp_target = pc4;   // fall through
    name       = "other";
    case (op)
      OP_LUI: begin
        name     = "lui";
        writes   = 1'b1;
        exp_data = imm_u;
      end
      OP_AUIPC: begin
        name     = "auipc";
        writes   = 1'b1;
        exp_data = pc_q + imm_u;
      end
      OP_IMM: begin
        name     = "alu_imm";
        writes   = 1'b1;
        opb      = (f3 == 3'b001 || f3 == 3'b101) ? {27'b0, w[24:20]} : imm_i;
        exp_data = alu_result(f3, (f3 == 3'b101) && w[30], a, opb);
      end
      OP_REG: begin
        name     = "alu_reg";
        writes   = 1'b1;
        exp_data = alu_result(f3, w[30], a, b);
      end
      OP_JAL: begin
        name       = "jal";
        writes     = 1'b1;
        exp_data   = pc4;
        taken      = 1'b1;
        exp_target = pc_q + imm_j;
      end
      OP_JALR: begin
        name       = "jalr";
        writes     = 1'b1;
        exp_data   = pc4;
        taken      = 1'b1;
        exp_target = (a + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        name  = "branch";
        taken = branch_taken(f3, a, b);
        if (taken) exp_target = pc_q + imm_b;
      end
      OP_LOAD: begin
        name     = "load";
        writes   = 1'b1;
        addr     = a + imm_i;
        mis      = misaligned(f3, addr);
        exp_data = load_value(f3, addr);
      end
      OP_STORE: begin
        name = "store";
        addr = a + imm_s;
        mis  = misaligned(f3, addr);
      end
      default: ;
    endcase
    exp_wen = writes && !stall_v && !(mis && op == OP_LOAD);
    @(posedge CLK);   // outputs settled and reg file not yet written
    assert (redirect.taken == taken)
      else mismatch({name, " taken"}, word_t'(taken), word_t'(redirect.taken));
    assert (redirect.brj_addr == exp_target)
      else mismatch({name, " brj_addr"}, exp_target, redirect.brj_addr);
    assert (redirect.mispredict == (pred ^ taken))
      else mismatch({name, " mispredict"}, word_t'(pred ^ taken),
                    word_t'(redirect.mispredict));
    assert (wb.wen == exp_wen)
      else mismatch({name, " wb.wen"}, word_t'(exp_wen), word_t'(wb.wen));
    if (exp_wen) begin
      assert (wb.rd == rd) else mismatch({name, " wb.rd"}, word_t'(rd), word_t'(wb.rd));
      assert (wb.data == exp_data) else mismatch({name, " wb.data"}, exp_data, wb.data);
    end
    assert (mal_load == (op == OP_LOAD && mis))
      else mismatch({name, " mal_load"}, word_t'(op == OP_LOAD && mis), word_t'(mal_load));
    assert (mal_store == (op == OP_STORE && mis))
      else mismatch({name, " mal_store"}, word_t'(op == OP_STORE && mis),
                    word_t'(mal_store));
    // stall does not gate the bus
    assert (dmem.ren == (op == OP_LOAD && !mis))
      else mismatch({name, " dmem.ren"}, word_t'(op == OP_LOAD && !mis), word_t'(dmem.ren));
    assert (dmem.wen == (op == OP_STORE && !mis))
      else mismatch({name, " dmem.wen"}, word_t'(op == OP_STORE && !mis),
                    word_t'(dmem.wen));
    if ((op == OP_LOAD || op == OP_STORE) && !mis) begin
      assert (dmem.addr == addr) else mismatch({name, " dmem.addr"}, addr, dmem.addr);
      assert (dmem.byte_en == byte_lanes(f3, addr))
        else mismatch({name, " byte_en"}, word_t'(byte_lanes(f3, addr)),
                      word_t'(dmem.byte_en));
    end
    if (op == OP_STORE && !mis) begin
      assert (dmem.wdata == store_data(f3, b))
        else mismatch("store wdata", store_data(f3, b), dmem.wdata);
    end
    if (exp_wen && rd != 5'd0) shadow[rd] = exp_data;   // x0 stays zero
    pc_q = pc_q + 32'd4;
  endtask

  // base setup through x1 then the access itself
  task automatic mem_item(input logic is_load, input logic stall_v);
    logic [2:0] f3;
    int         base, tgt;
    logic [11:0] off;
    f3 = 3'($urandom_range(0, 2));
    if (is_load && f3 != 3'b010 && $urandom_range(0, 1) == 1) f3 = f3 | 3'b100;  // unsigned
    base = $urandom_range(0, 1023);
    tgt  = $urandom_range(0, 1023);
    if (f3[1:0] == 2'b01) tgt = tgt & ~1;
    if (f3[1:0] == 2'b10) tgt = tgt & ~3;
    if (f3[1:0] != 2'b00 && $urandom_range(0, 7) == 0) begin
      tgt = tgt | ((f3[1:0] == 2'b10) ? $urandom_range(1, 3) : 1);   // misaligned
    end
    off = 12'(tgt - base);
    run_instr(i_word(12'(base), 5'd0, 3'b000, 5'd1, OP_IMM), 1'b0);
    if (is_load) run_instr(i_word(off, 5'd1, f3, pick_rd(), OP_LOAD), stall_v);
    else run_instr(s_word(off, 5'($urandom_range(0, 31)), 5'd1, f3), stall_v);
  endtask

  task automatic random_item();
    int unsigned kind, r;
    logic [2:0]  f3;
    reg_addr_t   rd, rs1, rs2;
    logic [11:0] imm12;
    logic        stall_v;
    kind    = $urandom_range(0, 9);
    r       = $urandom();
    rd      = pick_rd();
    rs1     = 5'($urandom_range(0, 31));
    rs2     = 5'($urandom_range(0, 31));
    f3      = 3'($urandom_range(0, 7));
    stall_v = ($urandom_range(0, 9) == 0);
    case (kind)
      0, 1, 2: run_instr(r_word(((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? 7'h20 : 7'h00,
                                rs2, rs1, f3, rd, OP_REG), stall_v);
      3, 4: begin
        imm12 = r[11:0];
        if (f3 == 3'b001) imm12 = {7'h00, r[4:0]};
        if (f3 == 3'b101) imm12 = {r[5] ? 7'h20 : 7'h00, r[4:0]};
        run_instr(i_word(imm12, rs1, f3, rd, OP_IMM), stall_v);
      end
      5: run_instr({r[31:12], rd, r[0] ? OP_LUI : OP_AUIPC}, stall_v);
      6: begin
        if (f3 == 3'b010 || f3 == 3'b011) f3 = 3'b000;   // no such branch
        if (r[14:13] == 2'b00) rs2 = rs1;                // equal operands now and then
        run_instr(b_word({r[12:1], 1'b0}, rs2, rs1, f3), stall_v);
      end
      7: begin
        if (r[0]) run_instr(j_word({r[20:1], 1'b0}, rd), stall_v);
        else run_instr(i_word(r[31:20], rs1, 3'b000, rd, OP_JALR), stall_v);
      end
      default: mem_item(kind == 8, stall_v);
    endcase
  endtask

  initial begin
    void'($urandom(3));
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), 8'(i ^ 8'hc3), 8'(~i), 8'(i + 8'h5a)};
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    pc_q                = 32'h0000_1000;
    nRST                = 1'b0;
    stall               = 1'b0;
    fetch_ex.instr      = 32'h0000_0013;   // addi x0, x0, 0
    fetch_ex.pc         = '0;
    fetch_ex.pc4        = 32'd4;
    fetch_ex.prediction = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST = 1'b1;

    assert (halt == 1'b0) else mismatch("halt after reset", 32'd0, word_t'(halt));
    run_instr(r_word(7'h00, 5'd3, 5'd2, 3'b000, 5'd5, OP_REG), 1'b0);   // cleared regs sum to 0

    // fill x2..x31 through lui then addi
    for (int i = 2; i < 32; i++) begin
      run_instr({20'($urandom()), 5'(i), OP_LUI}, 1'b0);
      run_instr(i_word(12'($urandom()), 5'(i), 3'b000, 5'(i), OP_IMM), 1'b0);
    end

    // write to x0 then read it back
    run_instr(i_word(12'h123, 5'd0, 3'b000, 5'd0, OP_IMM), 1'b0);
    run_instr(r_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd5, OP_REG), 1'b0);

    for (int n = 0; n < N_ITEMS; n++) begin
      random_item();
    end

    // stalled halt has no effect
    run_instr(HALT_WORD, 1'b1);
    @(negedge CLK);
    assert (halt == 1'b0) else mismatch("halt while stalled", 32'd0, word_t'(halt));
    run_instr(HALT_WORD, 1'b0);
    @(negedge CLK);
    assert (halt == 1'b1) else mismatch("halt rise", 32'd1, word_t'(halt));

    for (int n = 0; n < N_TAIL; n++) begin
      random_item();
    end
    assert (halt == 1'b1) else mismatch("halt sticky", 32'd1, word_t'(halt));

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/exec_stage_pkg.sv
// ----------------------------------------
// execute stage control and bus structs
// operand and write-back select codes
// ----------------------------------------
`default_nettype none

package exec_stage_pkg;
  import rv32_isa_pkg::*;

  typedef enum logic {A_RS1, A_PC} alu_a_sel_t;
  typedef enum logic [1:0] {B_RS2, B_IMM, B_SHAMT} alu_b_sel_t;
  typedef enum logic [1:0] {WB_LOAD, WB_PC4, WB_IMM_U, WB_ALU} wb_sel_t;

  // decoded instruction
  typedef struct packed {
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    alu_op_t      alu_op;
    alu_a_sel_t   alu_a_sel;
    alu_b_sel_t   alu_b_sel;
    word_t        imm;          // sign extended, per format
    wb_sel_t      wb_sel;
    logic         reg_wen;
    logic         dren;
    logic         dwen;
    load_type_t   load_type;    // also store width
    logic         branch;
    branch_type_t branch_type;
    logic         jump;         // jal or jalr
    logic         jalr;
    logic         halt;
  } ctrl_t;

  typedef struct packed {
    logic       ren;
    logic       wen;
    word_t      addr;
    word_t      wdata;
    logic [3:0] byte_en;
  } mem_req_t;

  typedef struct packed {
    word_t brj_addr;    // resolved next pc
    logic  taken;
    logic  mispredict;
  } redirect_t;

  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  typedef struct packed {
    instr_u instr;
    word_t  pc;
    word_t  pc4;
    logic   prediction;   // fetch guessed taken
  } fetch_ex_t;

endpackage

`default_nettype wire

// File: rtl/exec_stage_top.sv
// ----------------------------------------
// rv32i execute stage top level
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exec_stage_top import rv32_isa_pkg::*, exec_stage_pkg::*; #(
  parameter bit little_endian_bus = 1'b1
) (
  input  logic      CLK,
  input  logic      nRST,
  input  fetch_ex_t fetch_ex,
  input  logic      stall,        // from hazard logic
  input  word_t     dmem_rdata,
  output mem_req_t  dmem,
  output redirect_t redirect,
  output wb_t       wb,
  output logic      mal_load,
  output logic      mal_store,
  output logic      halt
);

  ctrl_t ctrl;
  word_t rs1_data, rs2_data;
  word_t alu_out;                 // also the data address
  word_t load_data;

  instr_decoder u_dec (
    .instr (fetch_ex.instr),
    .ctrl  (ctrl)
  );

  reg_file u_rf (
    .CLK      (CLK),
    .nRST     (nRST),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  int_execute u_ex (
    .ctrl       (ctrl),
    .pc         (fetch_ex.pc),
    .pc4        (fetch_ex.pc4),
    .prediction (fetch_ex.prediction),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_out    (alu_out),
    .redirect   (redirect)
  );

  load_store_unit #(.little_endian_bus(little_endian_bus)) u_lsu (
    .ctrl      (ctrl),
    .addr      (alu_out),
    .rs2_data  (rs2_data),
    .rdata     (dmem_rdata),
    .dmem      (dmem),
    .load_data (load_data),
    .mal_load  (mal_load),
    .mal_store (mal_store)
  );

  writeback_select u_wb (
    .CLK       (CLK),
    .nRST      (nRST),
    .ctrl      (ctrl),
    .stall     (stall),
    .mal_load  (mal_load),
    .load_data (load_data),
    .alu_out   (alu_out),
    .pc4       (fetch_ex.pc4),
    .wb        (wb),
    .halt      (halt)
  );

endmodule

`default_nettype wire

// File: rtl/instr_decoder.sv
// ----------------------------------------
// rv32i decoder, control and immediates
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv32_isa_pkg::*, exec_stage_pkg::*; (
  input  instr_u instr,
  output ctrl_t  ctrl
);

  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  logic  shift_imm;

  // funct3 plus bit 30 to alu op
  function automatic alu_op_t alu_fn(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_fn = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_fn = ALU_SLL;
      3'b010:  alu_fn = ALU_SLT;
      3'b011:  alu_fn = ALU_SLTU;
      3'b100:  alu_fn = ALU_XOR;
      3'b101:  alu_fn = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_fn = ALU_OR;
      default: alu_fn = ALU_AND;
    endcase
  endfunction

  assign imm_i = {{20{instr.i.imm11_00[11]}}, instr.i.imm11_00};
  assign imm_s = {{20{instr.s.imm11_05[6]}}, instr.s.imm11_05, instr.s.imm04_00};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_05, instr.b.imm04_01, 1'b0};
  assign imm_u = {instr.u.imm31_12, 12'b0};
  assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_01, 1'b0};

  assign shift_imm = (instr.i.funct3 == 3'b001) || (instr.i.funct3 == 3'b101);

  always_comb begin
    ctrl             = '0;          // no-op by default
    ctrl.rs1         = instr.r.rs1;
    ctrl.rs2         = instr.r.rs2;
    ctrl.rd          = instr.r.rd;
    ctrl.alu_op      = ALU_ADD;
    ctrl.alu_a_sel   = A_RS1;
    ctrl.alu_b_sel   = B_IMM;
    ctrl.wb_sel      = WB_ALU;
    ctrl.load_type   = load_type_t'(instr.i.funct3);
    ctrl.branch_type = branch_type_t'(instr.b.funct3);
    case (instr.r.opcode)
      LUI: begin
        ctrl.imm     = imm_u;
        ctrl.wb_sel  = WB_IMM_U;
        ctrl.reg_wen = 1'b1;
      end
      AUIPC: begin
        ctrl.imm       = imm_u;
        ctrl.alu_a_sel = A_PC;   // pc + imm
        ctrl.reg_wen   = 1'b1;
      end
      JAL: begin
        ctrl.imm     = imm_j;
        ctrl.jump    = 1'b1;
        ctrl.wb_sel  = WB_PC4;   // link
        ctrl.reg_wen = 1'b1;
      end
      JALR: begin
        ctrl.imm     = imm_i;
        ctrl.jump    = 1'b1;
        ctrl.jalr    = 1'b1;
        ctrl.wb_sel  = WB_PC4;
        ctrl.reg_wen = 1'b1;
      end
      BRANCH: begin
        ctrl.imm    = imm_b;
        ctrl.branch = 1'b1;
      end
      LOAD: begin
        ctrl.imm     = imm_i;
        ctrl.dren    = 1'b1;
        ctrl.wb_sel  = WB_LOAD;
        ctrl.reg_wen = 1'b1;
      end
      STORE: begin
        ctrl.imm  = imm_s;
        ctrl.dwen = 1'b1;
      end
      IMM: begin
        ctrl.imm       = imm_i;
        // bit 30 only means sra on srai
        ctrl.alu_op    = alu_fn(instr.i.funct3,
                                instr.r.funct7[5] && (instr.i.funct3 == 3'b101));
        ctrl.alu_b_sel = shift_imm ? B_SHAMT : B_IMM;
        ctrl.reg_wen   = 1'b1;
      end
      REG: begin
        ctrl.alu_op    = alu_fn(instr.r.funct3, instr.r.funct7[5]);
        ctrl.alu_b_sel = B_RS2;
        ctrl.reg_wen   = 1'b1;
      end
      HALT:    ctrl.halt = 1'b1;
      default: ;                 // illegal, stays a no-op
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/int_execute.sv
// ----------------------------------------
// operand muxes, alu, branch compare
// jump and branch targets, redirect
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_execute import rv32_isa_pkg::*, exec_stage_pkg::*; (
  input  ctrl_t     ctrl,
  input  word_t     pc,
  input  word_t     pc4,
  input  logic      prediction,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output word_t     alu_out,
  output redirect_t redirect
);

  word_t op_a, op_b;
  word_t pc_target;      // jal and branch share this adder
  word_t jump_target;
  logic  br_cond;

  assign op_a = (ctrl.alu_a_sel == A_PC) ? pc : rs1_data;

  always_comb begin
    case (ctrl.alu_b_sel)
      B_RS2:   op_b = rs2_data;
      B_SHAMT: op_b = {27'b0, ctrl.imm[4:0]};
      default: op_b = ctrl.imm;
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << op_b[4:0];
      ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> op_b[4:0];
      ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];  // keeps sign
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;
      default:  alu_out = '0;
    endcase
  end

  // branch condition on raw register data
  always_comb begin
    case (ctrl.branch_type)
      BEQ:     br_cond = (rs1_data == rs2_data);
      BNE:     br_cond = (rs1_data != rs2_data);
      BLT:     br_cond = ($signed(rs1_data) < $signed(rs2_data));
      BGE:     br_cond = ($signed(rs1_data) >= $signed(rs2_data));
      BLTU:    br_cond = (rs1_data < rs2_data);
      BGEU:    br_cond = (rs1_data >= rs2_data);
      default: br_cond = 1'b0;
    endcase
  end

  assign pc_target   = pc + ctrl.imm;
  assign jump_target = ctrl.jalr ? ((rs1_data + ctrl.imm) & ~32'd1) : pc_target;

  always_comb begin
    redirect.taken      = ctrl.jump | (ctrl.branch & br_cond);
    // jumps first, then taken branch, else fall through
    redirect.brj_addr   = ctrl.jump ? jump_target :
                          redirect.taken ? pc_target : pc4;
    redirect.mispredict = prediction ^ redirect.taken;
  end

endmodule

`default_nettype wire

// File: rtl/load_store_unit.sv
// ----------------------------------------
// byte enables, store data, endian swap
// misalignment check, load extension
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import rv32_isa_pkg::*, exec_stage_pkg::*; #(
  parameter bit little_endian_bus = 1'b1
) (
  input  ctrl_t    ctrl,
  input  word_t    addr,
  input  word_t    rs2_data,
  input  word_t    rdata,
  output mem_req_t dmem,
  output word_t    load_data,
  output logic     mal_load,
  output logic     mal_store
);

  logic [1:0] offset;
  logic [3:0] lanes;
  logic       mal;
  word_t      store_word, rdata_le;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  function automatic word_t swap_bytes(input word_t w);
    swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign offset = addr[1:0];

  always_comb begin
    lanes      = 4'b0000;
    store_word = rs2_data;
    mal        = 1'b0;
    case (ctrl.load_type)
      LB, LBU: begin
        lanes      = 4'b0001 << offset;
        store_word = {4{rs2_data[7:0]}};     // byte in every lane
      end
      LH, LHU: begin
        lanes      = offset[1] ? 4'b1100 : 4'b0011;
        store_word = {2{rs2_data[15:0]}};
        mal        = offset[0];              // odd halfword
      end
      LW: begin
        lanes = 4'b1111;
        mal   = (offset != 2'b00);
      end
      default: ;
    endcase
  end

  assign mal_load  = ctrl.dren & mal;
  assign mal_store = ctrl.dwen & mal;

  // big-endian bus swaps data words only
  assign rdata_le = little_endian_bus ? rdata : swap_bytes(rdata);

  always_comb begin
    dmem.ren     = ctrl.dren & ~mal;   // no bus cycle when misaligned
    dmem.wen     = ctrl.dwen & ~mal;
    dmem.addr    = addr;
    dmem.wdata   = little_endian_bus ? store_word : swap_bytes(store_word);
    dmem.byte_en = lanes;
  end

  assign ld_byte = rdata_le[{offset, 3'b000} +: 8];
  assign ld_half = offset[1] ? rdata_le[31:16] : rdata_le[15:0];

  always_comb begin
    case (ctrl.load_type)
      LB:      load_data = {{24{ld_byte[7]}}, ld_byte};
      LBU:     load_data = {24'b0, ld_byte};
      LH:      load_data = {{16{ld_half[15]}}, ld_half};
      LHU:     load_data = {16'b0, ld_half};
      default: load_data = rdata_le;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
// ----------------------------------------
// 32x32 integer register file, x0 hardwired
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv32_isa_pkg::*, exec_stage_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  wb_t       wb
);

  word_t regs [31:1];   // no storage for x0

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // async reads
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: rtl/rv32_isa_pkg.sv
// ----------------------------------------
// rv32i base types, opcodes, funct3 codes
// instruction formats and instruction union
// ----------------------------------------
`default_nettype none

package rv32_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMM    = 7'b0010011,
    REG    = 7'b0110011,
    HALT   = 7'h7f        // custom, all ones
  } opcode_t;

  // funct3 of loads, shared by SB/SH/SW
  typedef enum logic [2:0] {
    LB = 3'b000, LH = 3'b001, LW = 3'b010, LBU = 3'b100, LHU = 3'b101
  } load_type_t;

  typedef enum logic [2:0] {
    BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100,
    BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
  } branch_type_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // register fields sit at the same bits in every format
  typedef struct packed {
    logic [6:0] funct7; reg_addr_t rs2; reg_addr_t rs1;
    logic [2:0] funct3; reg_addr_t rd; opcode_t opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm11_00; reg_addr_t rs1;
    logic [2:0] funct3; reg_addr_t rd; opcode_t opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm11_05; reg_addr_t rs2; reg_addr_t rs1;
    logic [2:0] funct3; logic [4:0] imm04_00; opcode_t opcode;
  } s_type_t;

  typedef struct packed {
    logic imm12; logic [5:0] imm10_05; reg_addr_t rs2; reg_addr_t rs1;
    logic [2:0] funct3; logic [3:0] imm04_01; logic imm11; opcode_t opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm31_12; reg_addr_t rd; opcode_t opcode;
  } u_type_t;

  typedef struct packed {
    logic imm20; logic [9:0] imm10_01; logic imm11;
    logic [7:0] imm19_12; reg_addr_t rd; opcode_t opcode;
  } j_type_t;

  // one fetched word, viewed per opcode
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

endpackage

`default_nettype wire

// File: rtl/writeback_select.sv
// ----------------------------------------
// write-back mux, enable gating, halt flop
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module writeback_select import rv32_isa_pkg::*, exec_stage_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  ctrl_t ctrl,
  input  logic  stall,
  input  logic  mal_load,
  input  word_t load_data,
  input  word_t alu_out,
  input  word_t pc4,
  output wb_t   wb,
  output logic  halt
);

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD:  wb.data = load_data;
      WB_PC4:   wb.data = pc4;        // link address
      WB_IMM_U: wb.data = ctrl.imm;   // lui
      default:  wb.data = alu_out;
    endcase
    wb.rd  = ctrl.rd;
    // stalled or misaligned load writes nothing
    wb.wen = ctrl.reg_wen & ~stall & ~mal_load;
  end

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (ctrl.halt && !stall) begin
      halt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
rtl/rv32_isa_pkg.sv
rtl/exec_stage_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/int_execute.sv
rtl/load_store_unit.sv
rtl/writeback_select.sv
rtl/exec_stage_top.sv
bench/exec_stage_tb.sv
